// ==== common/icu_consts.svh ====
`ifndef ICU_CONSTS_SVH
`define ICU_CONSTS_SVH

// Operand and result width of the integer unit.
`define ICU_XLEN 64

// One divide iteration per quotient bit.
`define ICU_DIV_STEPS `ICU_XLEN

`endif

// ==== common/icu_op_pkg.sv ====
package icu_op_pkg;

    // ALU operation, driven by the decoder.
    typedef enum logic [5:0] {
        ADD    = 6'd0,
        SUB    = 6'd1,
        SLL    = 6'd2,
        SLT    = 6'd3,
        SLTU   = 6'd4,
        XOR    = 6'd5,
        SRL    = 6'd6,
        SRA    = 6'd7,
        OR     = 6'd8,
        AND    = 6'd9,
        PASS_B = 6'd10 // LUI.
    } alu_op_e;

    typedef enum logic [3:0] {
        NONE = 4'd0,
        EQ   = 4'd1,
        NE   = 4'd2,
        LT   = 4'd3,
        GE   = 4'd4,
        LTU  = 4'd5,
        GEU  = 4'd6
    } branch_cond_e;

    // A non-idle value doubles as the start strobe.
    typedef enum logic [3:0] {
        MUL_NONE = 4'd0,
        MUL      = 4'd1,
        MULH     = 4'd2,
        MULHSU   = 4'd3,
        MULHU    = 4'd4
    } mul_op_e;

    typedef enum logic [3:0] {
        DIV_NONE = 4'd0,
        DIV      = 4'd1,
        DIVU     = 4'd2,
        REM      = 4'd3,
        REMU     = 4'd4
    } div_op_e;

    // Result source at the unit output.
    typedef enum logic [1:0] {
        SEL_MUL = 2'd0,
        SEL_DIV = 2'd1,
        SEL_ALU = 2'd2
    } func_sel_e;

endpackage

// ==== common/icu_fsm_pkg.sv ====
package icu_fsm_pkg;

    // Divider sequencing.
    typedef enum logic [1:0] {
        IDLE = 2'd0, // Waiting for a divide op.
        RUN  = 2'd1, // One quotient bit per cycle.
        DONE = 2'd2  // Result fix-up and valid.
    } div_state_e;

endpackage

// ==== source/riscv_alu.sv ====
`include "icu_consts.svh"

module riscv_alu (
    input  icu_op_pkg::alu_op_e         i_riscv_alu_ctrl,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_alu_rs1data,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_alu_rs2data,
    output logic signed [`ICU_XLEN-1:0] o_riscv_alu_result
);

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = i_riscv_alu_rs2data[5:0]; // RV64 shift amount.

    assign lt_signed   = i_riscv_alu_rs1data < i_riscv_alu_rs2data;
    assign lt_unsigned = $unsigned(i_riscv_alu_rs1data) < $unsigned(i_riscv_alu_rs2data);

    always_comb begin
        case (i_riscv_alu_ctrl)
            icu_op_pkg::ADD:
                o_riscv_alu_result = i_riscv_alu_rs1data + i_riscv_alu_rs2data;
            icu_op_pkg::SUB:
                o_riscv_alu_result = i_riscv_alu_rs1data - i_riscv_alu_rs2data;
            icu_op_pkg::SLL:
                o_riscv_alu_result = i_riscv_alu_rs1data << shamt;
            icu_op_pkg::SLT:
                o_riscv_alu_result = {{(`ICU_XLEN-1){1'b0}}, lt_signed};
            icu_op_pkg::SLTU:
                o_riscv_alu_result = {{(`ICU_XLEN-1){1'b0}}, lt_unsigned};
            icu_op_pkg::XOR:
                o_riscv_alu_result = i_riscv_alu_rs1data ^ i_riscv_alu_rs2data;
            icu_op_pkg::SRL:
                o_riscv_alu_result = $unsigned(i_riscv_alu_rs1data) >> shamt;
            icu_op_pkg::SRA:
                o_riscv_alu_result = i_riscv_alu_rs1data >>> shamt; // Sign fill.
            icu_op_pkg::OR:
                o_riscv_alu_result = i_riscv_alu_rs1data | i_riscv_alu_rs2data;
            icu_op_pkg::AND:
                o_riscv_alu_result = i_riscv_alu_rs1data & i_riscv_alu_rs2data;
            icu_op_pkg::PASS_B:
                o_riscv_alu_result = i_riscv_alu_rs2data;
            default:
                o_riscv_alu_result = '0;
        endcase
    end

endmodule

// ==== source/riscv_branch.sv ====
`include "icu_consts.svh"

module riscv_branch (
    input  icu_op_pkg::branch_cond_e    i_riscv_branch_cond,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_branch_rs1data,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_branch_rs2data,
    output logic                        o_riscv_branch_taken
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = i_riscv_branch_rs1data == i_riscv_branch_rs2data;
    assign lt  = i_riscv_branch_rs1data < i_riscv_branch_rs2data;
    assign ltu = $unsigned(i_riscv_branch_rs1data) < $unsigned(i_riscv_branch_rs2data);

    always_comb begin
        case (i_riscv_branch_cond)
            icu_op_pkg::EQ:  o_riscv_branch_taken = eq;
            icu_op_pkg::NE:  o_riscv_branch_taken = !eq;
            icu_op_pkg::LT:  o_riscv_branch_taken = lt;
            icu_op_pkg::GE:  o_riscv_branch_taken = !lt;
            icu_op_pkg::LTU: o_riscv_branch_taken = ltu;
            icu_op_pkg::GEU: o_riscv_branch_taken = !ltu;
            default:         o_riscv_branch_taken = 1'b0; // Not a branch.
        endcase
    end

endmodule

// ==== source/riscv_multiplier.sv ====
`include "icu_consts.svh"

module riscv_multiplier (
    input  logic                        i_riscv_mul_clk,
    input  logic                        i_reset,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_mul_rs1data,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_mul_rs2data,
    input  icu_op_pkg::mul_op_e         i_riscv_mul_mulctrl,
    output logic                        o_riscv_mul_valid,
    output logic signed [`ICU_XLEN-1:0] o_riscv_mul_product
);

    logic                            a_sext;
    logic                            b_sext;
    logic                            valid_s1;
    logic                            valid_s2;
    icu_op_pkg::mul_op_e             op_s1;
    icu_op_pkg::mul_op_e             op_s2;
    logic signed [`ICU_XLEN:0]       opa_s1;
    logic signed [`ICU_XLEN:0]       opb_s1;
    logic signed [2*`ICU_XLEN+1:0]   prod_s2;

    // MULHU extends neither operand, MULHSU only rs1.
    assign a_sext = ((i_riscv_mul_mulctrl == icu_op_pkg::MULH) ||
                     (i_riscv_mul_mulctrl == icu_op_pkg::MULHSU)) &&
                    i_riscv_mul_rs1data[`ICU_XLEN-1];
    assign b_sext = (i_riscv_mul_mulctrl == icu_op_pkg::MULH) &&
                    i_riscv_mul_rs2data[`ICU_XLEN-1];

    // ############################################################
    // Pipeline valid bits.
    always_ff @(posedge i_riscv_mul_clk) begin
        if (i_reset) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= i_riscv_mul_mulctrl != icu_op_pkg::MUL_NONE;
            valid_s2 <= valid_s1;
        end
    end

    // ############################################################
    // Operand and product stages.
    always_ff @(posedge i_riscv_mul_clk) begin
        opa_s1  <= {a_sext, i_riscv_mul_rs1data};
        opb_s1  <= {b_sext, i_riscv_mul_rs2data};
        op_s1   <= i_riscv_mul_mulctrl;
        prod_s2 <= opa_s1 * opb_s1; // 65 x 65 signed.
        op_s2   <= op_s1;
    end

    assign o_riscv_mul_valid   = valid_s2;
    assign o_riscv_mul_product = (op_s2 == icu_op_pkg::MUL) ? prod_s2[`ICU_XLEN-1:0]
                                                            : prod_s2[2*`ICU_XLEN-1:`ICU_XLEN];

endmodule

// ==== riscv_divider/riscv_div_ctrl.sv ====
module riscv_div_ctrl (
    input  logic i_riscv_div_clk,
    input  logic i_reset,
    input  logic i_riscv_div_start,
    input  logic i_riscv_div_last,
    output logic o_riscv_div_load,
    output logic o_riscv_div_step,
    output logic o_riscv_div_done
);

    icu_fsm_pkg::div_state_e state;
    icu_fsm_pkg::div_state_e state_next;

    always_ff @(posedge i_riscv_div_clk) begin
        if (i_reset) begin
            state <= icu_fsm_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            icu_fsm_pkg::IDLE: begin
                if (i_riscv_div_start) begin
                    state_next = icu_fsm_pkg::RUN;
                end
            end
            icu_fsm_pkg::RUN: begin
                if (i_riscv_div_last) begin
                    state_next = icu_fsm_pkg::DONE; // Final step this cycle.
                end
            end
            icu_fsm_pkg::DONE: state_next = icu_fsm_pkg::IDLE;
            default:           state_next = icu_fsm_pkg::IDLE;
        endcase
    end

    // Start is only honoured in IDLE.
    assign o_riscv_div_load = (state == icu_fsm_pkg::IDLE) && i_riscv_div_start;
    assign o_riscv_div_step = state == icu_fsm_pkg::RUN;
    assign o_riscv_div_done = state == icu_fsm_pkg::DONE;

endmodule

// ==== riscv_divider/riscv_div_counter.sv ====
`include "icu_consts.svh"

module riscv_div_counter (
    input  logic i_riscv_div_clk,
    input  logic i_reset,
    input  logic i_riscv_div_clear,
    input  logic i_riscv_div_count,
    output logic o_riscv_div_last
);

    logic [6:0] step_cnt; // Steps done so far.

    always_ff @(posedge i_riscv_div_clk) begin
        if (i_reset || i_riscv_div_clear) begin
            step_cnt <= '0;
        end else if (i_riscv_div_count) begin
            step_cnt <= step_cnt + 7'd1;
        end
    end

    assign o_riscv_div_last = i_riscv_div_count && (step_cnt == 7'(`ICU_DIV_STEPS - 1));

endmodule

// ==== riscv_divider/riscv_divider.sv ====
`include "icu_consts.svh"

module riscv_divider (
    input  logic                        i_riscv_div_clk,
    input  logic                        i_reset,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_div_rs1data,
    input  logic signed [`ICU_XLEN-1:0] i_riscv_div_rs2data,
    input  icu_op_pkg::div_op_e         i_riscv_div_divctrl,
    output logic                        o_riscv_div_valid,
    output logic signed [`ICU_XLEN-1:0] o_riscv_div_result
);

    logic                  load;
    logic                  step;
    logic                  done;
    logic                  last;
    logic                  is_signed;
    logic                  is_rem;
    logic [`ICU_XLEN-1:0]  mag_a;
    logic [`ICU_XLEN-1:0]  mag_b;
    logic [`ICU_XLEN-1:0]  dividend_q;
    logic [`ICU_XLEN-1:0]  divisor_q;
    logic [`ICU_XLEN-1:0]  quo_q;
    logic [`ICU_XLEN-1:0]  rem_q;
    logic [`ICU_XLEN:0]    rem_shift;
    logic [`ICU_XLEN:0]    diff;
    logic [`ICU_XLEN-1:0]  result_next;
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    logic                  div_zero_q;
    logic                  overflow_q;
    icu_op_pkg::div_op_e   op_q;

    riscv_div_ctrl u_ctrl (
        .i_riscv_div_clk   (i_riscv_div_clk),
        .i_reset           (i_reset),
        .i_riscv_div_start (i_riscv_div_divctrl != icu_op_pkg::DIV_NONE),
        .i_riscv_div_last  (last),
        .o_riscv_div_load  (load),
        .o_riscv_div_step  (step),
        .o_riscv_div_done  (done)
    );

    riscv_div_counter u_counter (
        .i_riscv_div_clk   (i_riscv_div_clk),
        .i_reset           (i_reset),
        .i_riscv_div_clear (load),
        .i_riscv_div_count (step),
        .o_riscv_div_last  (last)
    );

    assign is_signed = (i_riscv_div_divctrl == icu_op_pkg::DIV) ||
                       (i_riscv_div_divctrl == icu_op_pkg::REM);
    assign mag_a = (is_signed && i_riscv_div_rs1data[`ICU_XLEN-1]) ? -i_riscv_div_rs1data
                                                                   : i_riscv_div_rs1data;
    assign mag_b = (is_signed && i_riscv_div_rs2data[`ICU_XLEN-1]) ? -i_riscv_div_rs2data
                                                                   : i_riscv_div_rs2data;

    // ############################################################
    // Restoring step. Dividend bits shift out of quo_q into rem.
    assign rem_shift = {rem_q, quo_q[`ICU_XLEN-1]};
    assign diff      = rem_shift - {1'b0, divisor_q};

    always_ff @(posedge i_riscv_div_clk) begin
        if (load) begin
            dividend_q <= i_riscv_div_rs1data;
            divisor_q  <= mag_b;
            quo_q      <= mag_a;
            rem_q      <= '0;
            op_q       <= i_riscv_div_divctrl;
            neg_quo_q  <= is_signed && (i_riscv_div_rs1data[`ICU_XLEN-1] ^
                                        i_riscv_div_rs2data[`ICU_XLEN-1]);
            neg_rem_q  <= is_signed && i_riscv_div_rs1data[`ICU_XLEN-1]; // Follows dividend.
            div_zero_q <= i_riscv_div_rs2data == '0;
            overflow_q <= is_signed && (i_riscv_div_rs1data == {1'b1, {(`ICU_XLEN-1){1'b0}}}) &&
                          (i_riscv_div_rs2data == '1);
        end else if (step) begin
            if (!diff[`ICU_XLEN]) begin
                rem_q <= diff[`ICU_XLEN-1:0];
                quo_q <= {quo_q[`ICU_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[`ICU_XLEN-1:0];
                quo_q <= {quo_q[`ICU_XLEN-2:0], 1'b0};
            end
        end
    end

    // ############################################################
    // Sign fix-up and special cases.
    assign is_rem = (op_q == icu_op_pkg::REM) || (op_q == icu_op_pkg::REMU);

    always_comb begin
        if (div_zero_q) begin
            result_next = is_rem ? dividend_q : '1;
        end else if (overflow_q) begin
            result_next = is_rem ? '0 : dividend_q;
        end else if (is_rem) begin
            result_next = neg_rem_q ? -rem_q : rem_q;
        end else begin
            result_next = neg_quo_q ? -quo_q : quo_q;
        end
    end

    always_ff @(posedge i_riscv_div_clk) begin
        if (i_reset) begin
            o_riscv_div_valid <= 1'b0;
        end else begin
            o_riscv_div_valid <= done; // One cycle after DONE.
        end
    end

    always_ff @(posedge i_riscv_div_clk) begin
        if (done) begin
            o_riscv_div_result <= result_next;
        end
    end

endmodule

// ==== source/riscv_icu.sv ====
`include "icu_consts.svh"

module riscv_icu (
    input  logic                        i_riscv_icu_clk,
    input  logic                        i_reset,
    input  logic signed [`ICU_XLEN-1:0] i_rs1data,
    input  logic signed [`ICU_XLEN-1:0] i_rs2data,
    input  logic signed [`ICU_XLEN-1:0] i_alurs1data,
    input  logic signed [`ICU_XLEN-1:0] i_alurs2data,
    input  icu_op_pkg::branch_cond_e    i_bcond,
    input  icu_op_pkg::mul_op_e         i_mulctrl,
    input  icu_op_pkg::div_op_e         i_divctrl,
    input  icu_op_pkg::alu_op_e         i_aluctrl,
    input  icu_op_pkg::func_sel_e       i_funcsel,
    output logic                        o_branch_taken,
    output logic                        o_valid,
    output logic signed [`ICU_XLEN-1:0] o_result
);

    logic                        mul_valid;
    logic                        div_valid;
    logic signed [`ICU_XLEN-1:0] alu_result;
    logic signed [`ICU_XLEN-1:0] mul_result;
    logic signed [`ICU_XLEN-1:0] div_result;

    riscv_alu u_alu (
        .i_riscv_alu_ctrl    (i_aluctrl),
        .i_riscv_alu_rs1data (i_alurs1data),
        .i_riscv_alu_rs2data (i_alurs2data),
        .o_riscv_alu_result  (alu_result)
    );

    riscv_branch u_branch (
        .i_riscv_branch_cond    (i_bcond),
        .i_riscv_branch_rs1data (i_rs1data),
        .i_riscv_branch_rs2data (i_rs2data),
        .o_riscv_branch_taken   (o_branch_taken)
    );

    riscv_multiplier u_mul (
        .i_riscv_mul_clk     (i_riscv_icu_clk),
        .i_reset             (i_reset),
        .i_riscv_mul_rs1data (i_rs1data),
        .i_riscv_mul_rs2data (i_rs2data),
        .i_riscv_mul_mulctrl (i_mulctrl),
        .o_riscv_mul_valid   (mul_valid),
        .o_riscv_mul_product (mul_result)
    );

    riscv_divider u_divider (
        .i_riscv_div_clk     (i_riscv_icu_clk),
        .i_reset             (i_reset),
        .i_riscv_div_rs1data (i_rs1data),
        .i_riscv_div_rs2data (i_rs2data),
        .i_riscv_div_divctrl (i_divctrl),
        .o_riscv_div_valid   (div_valid),
        .o_riscv_div_result  (div_result)
    );

    // Only one of the two is pending at a time.
    assign o_valid = mul_valid || div_valid;

    always_comb begin
        case (i_funcsel)
            icu_op_pkg::SEL_MUL: o_result = mul_result;
            icu_op_pkg::SEL_DIV: o_result = div_result;
            icu_op_pkg::SEL_ALU: o_result = alu_result;
            default:             o_result = '0;
        endcase
    end

endmodule

// ==== tests/riscv_icu_sva.sv ====
`include "icu_consts.svh"

module riscv_icu_sva (
    input logic                      i_riscv_icu_clk,
    input logic                      i_reset,
    input logic [`ICU_XLEN-1:0]      i_rs1data,
    input logic [`ICU_XLEN-1:0]      i_rs2data,
    input logic [`ICU_XLEN-1:0]      i_alurs1data,
    input logic [`ICU_XLEN-1:0]      i_alurs2data,
    input icu_op_pkg::branch_cond_e  i_bcond,
    input icu_op_pkg::mul_op_e       i_mulctrl,
    input icu_op_pkg::div_op_e       i_divctrl,
    input icu_op_pkg::alu_op_e       i_aluctrl,
    input icu_op_pkg::func_sel_e     i_funcsel,
    input logic                      o_branch_taken,
    input logic                      o_valid,
    input logic [`ICU_XLEN-1:0]      o_result
);
    timeunit 1ns;
    timeprecision 100ps;

    bit                   check_failed; // Read by the testbench.
    logic                 issued;       // Any mul or div seen since reset.
    logic [`ICU_XLEN-1:0] mul_exp_s1;
    logic [`ICU_XLEN-1:0] mul_exp_s2;
    logic [`ICU_XLEN-1:0] div_exp;

    // ############################################################
    // Reference models.
    function automatic logic [1:0] less_than(logic [`ICU_XLEN-1:0] a, logic [`ICU_XLEN-1:0] b);
        logic [`ICU_XLEN-1:0] diff;
        diff = a - b;
        // Bit 1 signed, bit 0 unsigned.
        if (a[`ICU_XLEN-1] != b[`ICU_XLEN-1]) begin
            return {a[`ICU_XLEN-1], b[`ICU_XLEN-1]};
        end
        return {2{diff[`ICU_XLEN-1]}};
    endfunction

    function automatic logic [`ICU_XLEN-1:0] alu_ref(icu_op_pkg::alu_op_e op,
                                                      logic [`ICU_XLEN-1:0] a,
                                                      logic [`ICU_XLEN-1:0] b);
        logic [5:0]           sh;
        logic [`ICU_XLEN-1:0] fill;
        logic [1:0]           lt;
        sh   = b[5:0];
        fill = a[`ICU_XLEN-1] ? ~({`ICU_XLEN{1'b1}} >> sh) : '0; // Sign bits for SRA.
        lt   = less_than(a, b);
        case (op)
            icu_op_pkg::ADD:    return a + b;
            icu_op_pkg::SUB:    return a - b;
            icu_op_pkg::SLL:    return a << sh;
            icu_op_pkg::SLT:    return {{(`ICU_XLEN-1){1'b0}}, lt[1]};
            icu_op_pkg::SLTU:   return {{(`ICU_XLEN-1){1'b0}}, lt[0]};
            icu_op_pkg::XOR:    return a ^ b;
            icu_op_pkg::SRL:    return a >> sh;
            icu_op_pkg::SRA:    return (a >> sh) | fill;
            icu_op_pkg::OR:     return a | b;
            icu_op_pkg::AND:    return a & b;
            icu_op_pkg::PASS_B: return b;
            default:            return '0;
        endcase
    endfunction

    function automatic logic branch_ref(icu_op_pkg::branch_cond_e cond,
                                        logic [`ICU_XLEN-1:0] a, logic [`ICU_XLEN-1:0] b);
        logic [1:0] lt;
        lt = less_than(a, b);
        case (cond)
            icu_op_pkg::EQ:  return a == b;
            icu_op_pkg::NE:  return a != b;
            icu_op_pkg::LT:  return lt[1];
            icu_op_pkg::GE:  return !lt[1];
            icu_op_pkg::LTU: return lt[0];
            icu_op_pkg::GEU: return !lt[0];
            default:         return 1'b0;
        endcase
    endfunction

    // Unsigned product, then two's complement corrections on the high half.
    function automatic logic [`ICU_XLEN-1:0] mul_ref(icu_op_pkg::mul_op_e op,
                                                      logic [`ICU_XLEN-1:0] a,
                                                      logic [`ICU_XLEN-1:0] b);
        logic [2*`ICU_XLEN-1:0] prod;
        logic [`ICU_XLEN-1:0]   high;
        prod = {{`ICU_XLEN{1'b0}}, a} * {{`ICU_XLEN{1'b0}}, b};
        high = prod[2*`ICU_XLEN-1:`ICU_XLEN];
        case (op)
            icu_op_pkg::MUL:    return prod[`ICU_XLEN-1:0];
            icu_op_pkg::MULHU:  return high;
            icu_op_pkg::MULHSU: return high - (a[`ICU_XLEN-1] ? b : '0);
            default:            return high - (a[`ICU_XLEN-1] ? b : '0) -
                                       (b[`ICU_XLEN-1] ? a : '0);
        endcase
    endfunction

    function automatic logic [`ICU_XLEN-1:0] div_ref(icu_op_pkg::div_op_e op,
                                                      logic [`ICU_XLEN-1:0] a,
                                                      logic [`ICU_XLEN-1:0] b);
        logic is_sgn;
        logic is_rem;
        is_sgn = (op == icu_op_pkg::DIV) || (op == icu_op_pkg::REM);
        is_rem = (op == icu_op_pkg::REM) || (op == icu_op_pkg::REMU);
        if (b == '0) begin
            return is_rem ? a : '1;
        end
        if (is_sgn && (a == {1'b1, {(`ICU_XLEN-1){1'b0}}}) && (b == '1)) begin
            return is_rem ? '0 : a; // Signed overflow.
        end
        if (is_sgn && is_rem) begin
            return $signed(a) % $signed(b);
        end
        if (is_sgn) begin
            return $signed(a) / $signed(b);
        end
        if (is_rem) begin
            return a % b;
        end
        return a / b;
    endfunction

    // ############################################################
    // Expected results, aligned with the DUT latency.
    always_ff @(posedge i_riscv_icu_clk) begin
        if (i_reset) begin
            issued <= 1'b0;
        end else if ((i_mulctrl != icu_op_pkg::MUL_NONE) ||
                     (i_divctrl != icu_op_pkg::DIV_NONE)) begin
            issued <= 1'b1;
        end
    end

    always_ff @(posedge i_riscv_icu_clk) begin
        mul_exp_s1 <= mul_ref(i_mulctrl, i_rs1data, i_rs2data);
        mul_exp_s2 <= mul_exp_s1;
        if (i_divctrl != icu_op_pkg::DIV_NONE) begin
            div_exp <= div_ref(i_divctrl, i_rs1data, i_rs2data); // One divide at a time.
        end
    end

    // ############################################################
    // Checks.
    a_alu: assert property (@(posedge i_riscv_icu_clk) disable iff (i_reset)
        (i_funcsel == icu_op_pkg::SEL_ALU) |->
            (o_result == alu_ref(i_aluctrl, i_alurs1data, i_alurs2data)))
        else begin
            $error("Error o_result 0x%h expected 0x%h", $sampled(o_result),
                   alu_ref($sampled(i_aluctrl), $sampled(i_alurs1data), $sampled(i_alurs2data)));
            check_failed = 1'b1;
        end

    a_branch: assert property (@(posedge i_riscv_icu_clk) disable iff (i_reset)
        o_branch_taken == branch_ref(i_bcond, i_rs1data, i_rs2data))
        else begin
            $error("Error o_branch_taken 0x%h expected 0x%h", $sampled(o_branch_taken),
                   branch_ref($sampled(i_bcond), $sampled(i_rs1data), $sampled(i_rs2data)));
            check_failed = 1'b1;
        end

    a_mul: assert property (@(posedge i_riscv_icu_clk) disable iff (i_reset)
        (i_mulctrl != icu_op_pkg::MUL_NONE) |-> ##2 (o_valid && (o_result == mul_exp_s2)))
        else begin
            $error("Error o_valid 0x%h o_result 0x%h expected 0x%h", $sampled(o_valid),
                   $sampled(o_result), $sampled(mul_exp_s2));
            check_failed = 1'b1;
        end

    a_div_quiet: assert property (@(posedge i_riscv_icu_clk) disable iff (i_reset)
        (i_divctrl != icu_op_pkg::DIV_NONE) |=> (!o_valid) [*(`ICU_DIV_STEPS + 1)])
        else begin
            $error("Error o_valid 0x%h expected 0x0 while dividing", $sampled(o_valid));
            check_failed = 1'b1;
        end

    a_div: assert property (@(posedge i_riscv_icu_clk) disable iff (i_reset)
        (i_divctrl != icu_op_pkg::DIV_NONE) |->
            ##(`ICU_DIV_STEPS + 2) (o_valid && (o_result == div_exp)))
        else begin
            $error("Error o_valid 0x%h o_result 0x%h expected 0x%h", $sampled(o_valid),
                   $sampled(o_result), $sampled(div_exp));
            check_failed = 1'b1;
        end

    a_quiet_after_reset: assert property (@(posedge i_riscv_icu_clk) disable iff (i_reset)
        !issued |-> !o_valid)
        else begin
            $error("Error o_valid 0x%h expected 0x0 before any issue", $sampled(o_valid));
            check_failed = 1'b1;
        end

endmodule

// ==== tests/riscv_icu_tb.sv ====
`include "icu_consts.svh"

module riscv_icu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // About 30 divides of 67 cycles and 700 short ops, with ample margin.
    localparam int TIMEOUT_CYCLES = 6000;

    logic                      clk;
    logic                      reset;
    logic [`ICU_XLEN-1:0]      rs1data;
    logic [`ICU_XLEN-1:0]      rs2data;
    logic [`ICU_XLEN-1:0]      alurs1data;
    logic [`ICU_XLEN-1:0]      alurs2data;
    icu_op_pkg::branch_cond_e  bcond;
    icu_op_pkg::mul_op_e       mulctrl;
    icu_op_pkg::div_op_e       divctrl;
    icu_op_pkg::alu_op_e       aluctrl;
    icu_op_pkg::func_sel_e     funcsel;
    logic                      branch_taken;
    logic                      valid;
    logic [`ICU_XLEN-1:0]      result;
    logic [`ICU_XLEN-1:0]      lfsr_state;
    logic [`ICU_XLEN-1:0]      word_a;
    logic [`ICU_XLEN-1:0]      word_b;
    int                        cycle_count = 0;

    riscv_icu riscv_icu_inst (
        .i_riscv_icu_clk (clk),
        .i_reset         (reset),
        .i_rs1data       (rs1data),
        .i_rs2data       (rs2data),
        .i_alurs1data    (alurs1data),
        .i_alurs2data    (alurs2data),
        .i_bcond         (bcond),
        .i_mulctrl       (mulctrl),
        .i_divctrl       (divctrl),
        .i_aluctrl       (aluctrl),
        .i_funcsel       (funcsel),
        .o_branch_taken  (branch_taken),
        .o_valid         (valid),
        .o_result        (result)
    );

    bind riscv_icu riscv_icu_sva riscv_icu_sva_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ############################################################
    // Stimulus helpers.
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 64'hD800_0000_0000_0000; // x^64+x^63+x^61+x^60+1.
        end
        return out;
    endfunction

    function automatic logic [`ICU_XLEN-1:0] rand_word();
        logic [`ICU_XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < `ICU_XLEN; i++) begin
            w = {w[`ICU_XLEN-2:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic [`ICU_XLEN-1:0] corner_value(int idx);
        case (idx)
            0:       return 64'h0000_0000_0000_0000;
            1:       return 64'h0000_0000_0000_0001;
            2:       return 64'hFFFF_FFFF_FFFF_FFFF;
            3:       return 64'h8000_0000_0000_0000; // Most negative.
            default: return 64'h7FFF_FFFF_FFFF_FFFF;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_valid();
        while (!valid) begin
            next_cycle();
        end
        next_cycle(); // Hold funcsel over the sampling edge.
    endtask

    task automatic apply_alu(icu_op_pkg::alu_op_e op, logic [`ICU_XLEN-1:0] a,
                             logic [`ICU_XLEN-1:0] b);
        funcsel    = icu_op_pkg::SEL_ALU;
        aluctrl    = op;
        alurs1data = a;
        alurs2data = b;
        next_cycle();
    endtask

    task automatic apply_branch(icu_op_pkg::branch_cond_e cond, logic [`ICU_XLEN-1:0] a,
                                logic [`ICU_XLEN-1:0] b);
        bcond   = cond;
        rs1data = a;
        rs2data = b;
        next_cycle();
    endtask

    task automatic issue_mul(icu_op_pkg::mul_op_e op, logic [`ICU_XLEN-1:0] a,
                             logic [`ICU_XLEN-1:0] b);
        funcsel = icu_op_pkg::SEL_MUL;
        mulctrl = op;
        rs1data = a;
        rs2data = b;
        next_cycle();
        mulctrl = icu_op_pkg::MUL_NONE;
    endtask

    task automatic issue_div(icu_op_pkg::div_op_e op, logic [`ICU_XLEN-1:0] a,
                             logic [`ICU_XLEN-1:0] b);
        funcsel = icu_op_pkg::SEL_DIV;
        divctrl = op;
        rs1data = a;
        rs2data = b;
        next_cycle();
        divctrl = icu_op_pkg::DIV_NONE;
        wait_valid();
    endtask

    // ############################################################
    // Run limits and failure watch.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (riscv_icu_inst.riscv_icu_sva_inst.check_failed) begin
            $display("An assertion check failed, stopping the run");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    // ############################################################
    // Test sequence.
    initial begin
        reset      = 1'b1;
        rs1data    = '0;
        rs2data    = '0;
        alurs1data = '0;
        alurs2data = '0;
        bcond      = icu_op_pkg::NONE;
        mulctrl    = icu_op_pkg::MUL_NONE;
        divctrl    = icu_op_pkg::DIV_NONE;
        aluctrl    = icu_op_pkg::ADD;
        funcsel    = icu_op_pkg::SEL_ALU;
        lfsr_state = 64'd79;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // ALU and branch first, so valid must stay low.
        for (int op = 0; op <= 10; op++) begin
            for (int i = 0; i < 25; i++) begin
                apply_alu(icu_op_pkg::alu_op_e'(op), corner_value(i / 5), corner_value(i % 5));
            end
            repeat (6) apply_alu(icu_op_pkg::alu_op_e'(op), rand_word(), rand_word());
        end
        apply_alu(icu_op_pkg::alu_op_e'(6'h3F), rand_word(), rand_word()); // Unused code.

        for (int c = 0; c <= 6; c++) begin
            for (int i = 0; i < 25; i++) begin
                apply_branch(icu_op_pkg::branch_cond_e'(c), corner_value(i / 5), corner_value(i % 5));
            end
            word_a = rand_word();
            apply_branch(icu_op_pkg::branch_cond_e'(c), word_a, word_a);
            repeat (4) apply_branch(icu_op_pkg::branch_cond_e'(c), rand_word(), rand_word());
        end

        // Single multiplies, then back-to-back pairs.
        for (int op = 1; op <= 4; op++) begin
            for (int i = 0; i < 25; i++) begin
                issue_mul(icu_op_pkg::mul_op_e'(op), corner_value(i / 5), corner_value(i % 5));
                wait_valid();
            end
            repeat (4) begin
                issue_mul(icu_op_pkg::mul_op_e'(op), rand_word(), rand_word());
                wait_valid();
            end
            issue_mul(icu_op_pkg::mul_op_e'(op), rand_word(), rand_word());
            issue_mul(icu_op_pkg::mul_op_e'(5 - op), rand_word(), rand_word());
            wait_valid();
            wait_valid();
        end

        // Divides, one at a time.
        for (int op = 1; op <= 4; op++) begin
            issue_div(icu_op_pkg::div_op_e'(op), rand_word(), '0);
            issue_div(icu_op_pkg::div_op_e'(op), corner_value(3), corner_value(2));
            issue_div(icu_op_pkg::div_op_e'(op), -64'sd7, 64'sd2);
            issue_div(icu_op_pkg::div_op_e'(op), rand_word(), rand_word());
            repeat (3) begin
                word_a = rand_word();
                word_b = rand_word() >> 40;
                if (lfsr_bit()) begin
                    word_b = -word_b;
                end
                issue_div(icu_op_pkg::div_op_e'(op), word_a, word_b);
            end
        end

        next_cycle();
        if (riscv_icu_inst.riscv_icu_sva_inst.check_failed) begin
            $display("sim failed");
            $fatal(1, "assertion failure at end of run");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+common
common/icu_op_pkg.sv
common/icu_fsm_pkg.sv
source/riscv_alu.sv
source/riscv_branch.sv
source/riscv_multiplier.sv
riscv_divider/riscv_div_ctrl.sv
riscv_divider/riscv_div_counter.sv
riscv_divider/riscv_divider.sv
source/riscv_icu.sv
tests/riscv_icu_sva.sv
tests/riscv_icu_tb.sv
